/* design/dma_config.svh */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// ***************************************************************************
// datapath widths
// ***************************************************************************
`define DMA_DATA_W         128  // beat width in bits
`define DMA_W_BCNT         16   // bytes per beat
`define DMA_LEN_WIDTH      13   // byte length field
`define DMA_ADDR_WIDTH     64   // host address
`define DMA_HEAD_W         128  // response head

// ***************************************************************************
// buffer depths
// ***************************************************************************
`define RSP_FIFO_DEPTH_LOG 6    // 64 beats of data, 1024 bytes
`define HEAD_DEPTH_LOG     2    // merged heads in flight

`endif

/* design/dma_pcie_pkg.sv */
package dma_pcie_pkg;

    // negotiated max read request size, same code as the link config space
    typedef enum logic [2:0] {
        FRAG_128B  = 3'd0,
        FRAG_256B  = 3'd1,
        FRAG_512B  = 3'd2,
        FRAG_1024B = 3'd3,
        FRAG_2048B = 3'd4,
        FRAG_4096B = 3'd5
    } pcie_frag_sz_e;

    // fragment size counted in 16-byte beats (8 << code)
    function automatic logic [8:0] frag_max_beats(pcie_frag_sz_e sz);
        return 9'd8 << sz;
    endfunction

endpackage

/* design/dma_rsp_pkg.sv */
`include "dma_config.svh"

package dma_rsp_pkg;

    // response head, laid out as on the RDMA side
    typedef struct packed {
        logic [31:0]                    rsvd_hi;   // 127:96
        logic [`DMA_ADDR_WIDTH-1:0]     addr;      // 95:32
        logic [31-`DMA_LEN_WIDTH:0]     rsvd_mid;  // 31:13
        logic [`DMA_LEN_WIDTH-1:0]      byte_len;  // 12:0
    } rsp_head_t;

    // sub-response beat from the PCIe side
    typedef struct packed {
        logic                           last;  // last beat of this sub-response
        logic [`DMA_DATA_W-1:0]         data;
        rsp_head_t                      head;  // first beat only
    } sub_rsp_beat_t;

    // merged response beat towards RDMA
    typedef struct packed {
        logic                           last;  // from total length
        logic [`DMA_DATA_W-1:0]         data;
        rsp_head_t                      head;  // held for the whole packet
    } rsp_beat_t;

    // partial beat into the byte packer
    typedef struct packed {
        logic                           eop;   // end of emitted response
        logic [4:0]                     blen;  // 1..16 valid low bytes
        logic [`DMA_DATA_W-1:0]         data;
    } pack_beat_t;

endpackage

/* design/dma_sync_fifo.sv */
`timescale 1ns/1ps

module dma_sync_fifo #(
    parameter int DSIZE = 128,  // word width
    parameter int ASIZE = 2     // log2 depth
) (
    input  logic             dma_clk,
    input  logic             rst_n,
    input  logic             wen,
    input  logic [DSIZE-1:0] din,
    input  logic             ren,
    output logic [DSIZE-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic [DSIZE-1:0] mem [2**ASIZE];  // ring storage
    logic [ASIZE:0]   wr_ptr;          // extra msb tells wrap
    logic [ASIZE:0]   rd_ptr;

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wen) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ren) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge dma_clk) begin
        if (wen) begin
            mem[wr_ptr[ASIZE-1:0]] <= din;
        end
    end

    assign dout  = mem[rd_ptr[ASIZE-1:0]];  // fall-through head word
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ASIZE] != rd_ptr[ASIZE]) &&
                   (wr_ptr[ASIZE-1:0] == rd_ptr[ASIZE-1:0]);  // same slot, other lap

    // the caller's flow control must keep the pointers within one lap
    a_no_overrun: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !(wen && full) && !(ren && empty));

endmodule

/* design/rsp_data_fifo.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module rsp_data_fifo (
    input  logic                    dma_clk,
    input  logic                    rst_n,
    input  logic                    pack_valid,
    input  dma_rsp_pkg::pack_beat_t pack_beat,
    output logic                    pack_ready,
    output logic                    beat_valid,
    output logic [`DMA_DATA_W-1:0]  beat_data,
    input  logic                    beat_ready
);

    localparam int DW    = `DMA_DATA_W;
    localparam int RES_W = DW - 8;  // up to 15 carried bytes

    logic [RES_W-1:0]    res_data;    // residue, zero above res_cnt
    logic [3:0]          res_cnt;     // residue bytes
    logic                flush_pend;  // eop remainder still to write
    logic                wr_en_q;
    logic [DW-1:0]       wr_data_q;
    logic                buf_full;
    logic                buf_empty;
    logic                pack_fire;
    logic [DW-1:0]       in_mask;
    logic [RES_W+DW-1:0] comb;        // residue plus new bytes
    logic [4:0]          total;       // bytes in comb, 1..31

    assign pack_ready = !buf_full && !flush_pend;  // one dead cycle per split flush
    assign pack_fire  = pack_valid && pack_ready;

    // keep only the valid low bytes of the incoming beat
    assign in_mask = pack_beat.blen[4] ? {DW{1'b1}} :
                     ((DW'(1) << {pack_beat.blen[3:0], 3'b000}) - DW'(1));

    // new bytes land right above the residue
    assign comb  = {{DW{1'b0}}, res_data} |
                   ({{RES_W{1'b0}}, pack_beat.data & in_mask} << {res_cnt, 3'b000});
    assign total = {1'b0, res_cnt} + pack_beat.blen;

    // ***********************************************************************
    // packer control
    // ***********************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            res_data   <= '0;
            res_cnt    <= '0;
            flush_pend <= 1'b0;
            wr_en_q    <= 1'b0;
        end else if (flush_pend) begin  // write the zero-padded tail
            res_data   <= '0;
            res_cnt    <= '0;
            flush_pend <= 1'b0;
            wr_en_q    <= 1'b1;
        end else if (pack_fire) begin
            wr_en_q    <= total[4] || pack_beat.eop;  // full beat or final tail
            flush_pend <= pack_beat.eop && (total > 5'd16);
            if (total[4]) begin
                res_data <= comb[RES_W+DW-1:DW];  // overflow bytes carry on
                res_cnt  <= total[3:0];           // total - 16
            end else if (pack_beat.eop) begin
                res_data <= '0;
                res_cnt  <= '0;
            end else begin
                res_data <= comb[RES_W-1:0];
                res_cnt  <= total[3:0];
            end
        end else begin
            wr_en_q <= 1'b0;
        end
    end

    always_ff @(posedge dma_clk) begin
        if (flush_pend) begin
            wr_data_q <= {8'h00, res_data};
        end else if (pack_fire) begin
            wr_data_q <= comb[DW-1:0];  // upper bytes already zero on a short tail
        end
    end

    // ***********************************************************************
    // beat buffer
    // ***********************************************************************
    dma_sync_fifo #(
        .DSIZE (DW),
        .ASIZE (`RSP_FIFO_DEPTH_LOG)
    ) beat_fifo_i (
        .dma_clk (dma_clk),
        .rst_n   (rst_n),
        .wen     (wr_en_q),
        .din     (wr_data_q),
        .ren     (beat_valid && beat_ready),
        .dout    (beat_data),
        .full    (buf_full),
        .empty   (buf_empty)
    );

    assign beat_valid = !buf_empty;

endmodule

/* design/sub_req_rsp_concat.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module sub_req_rsp_concat #(
    parameter int HEAD_DEPTH_LOG = `HEAD_DEPTH_LOG
) (
    input  logic                        dma_clk,
    input  logic                        rst_n,
    input  logic                        emit,           // final sub-response of a request
    input  logic                        sub_rsp_valid,
    input  dma_rsp_pkg::sub_rsp_beat_t  sub_rsp,
    output logic                        sub_rsp_ready,
    input  dma_pcie_pkg::pcie_frag_sz_e max_rd_req_sz,
    output logic                        is_avail,
    output logic                        pack_valid,     // packer side, observable
    output dma_rsp_pkg::pack_beat_t     pack_beat,
    output logic                        beat_valid,
    output logic [`DMA_DATA_W-1:0]      beat_data,
    output logic                        beat_ready,
    output logic                        rsp_valid,
    output dma_rsp_pkg::rsp_beat_t      rsp,
    input  logic                        rsp_ready
);

    import dma_pcie_pkg::*;
    import dma_rsp_pkg::*;

    localparam int LW = `DMA_LEN_WIDTH;
    localparam int BC = `DMA_W_BCNT;
    localparam int BS = $clog2(`DMA_W_BCNT);

    typedef enum logic [1:0] {
        RSP_START,  // next beat opens a request
        SUB_START,  // next beat opens a later sub-response
        SUB_BODY
    } concat_state_e;

    concat_state_e              state;
    logic                       sub_sop;
    logic                       in_fire;
    logic                       out_fire;
    logic                       out_last;
    logic                       pack_ready;
    logic                       blocked;
    logic                       credit_fail;
    logic                       head_push;
    logic                       head_full;
    logic                       head_empty;
    rsp_head_t                  head_in;
    rsp_head_t                  head_out;
    logic [`DMA_ADDR_WIDTH-1:0] hd_addr;     // first sub-response address
    logic [LW-1:0]              hd_len;      // running total length
    logic [LW-1:0]              nxt_len;
    logic [LW-1:0]              in_left;     // bytes left in sub-response
    logic [LW-1:0]              left;
    logic [LW-1:0]              occ_bytes;   // data buffer plus packer
    logic [LW-1:0]              occ_nxt;
    logic [LW-BS-1:0]           occ_beats;
    logic [LW-1:0]              out_cnt;     // bytes sent of current packet
    logic [LW-1:0]              out_left;

    // ***********************************************************************
    // input side and credit check
    // ***********************************************************************
    assign sub_sop   = (state != SUB_BODY);
    assign occ_beats = occ_bytes[LW-1:BS] + (LW-BS)'(|occ_bytes[BS-1:0]);  // ceil
    assign credit_fail = (10'(occ_beats) + 10'(frag_max_beats(max_rd_req_sz)))
                         > 10'(1 << `RSP_FIFO_DEPTH_LOG);
    assign blocked   = sub_sop && (credit_fail || head_full);  // started ones run through

    assign pack_valid    = sub_rsp_valid && !blocked;
    assign sub_rsp_ready = pack_ready && !blocked;
    assign in_fire       = sub_rsp_valid && sub_rsp_ready;

    assign left           = sub_sop ? sub_rsp.head.byte_len : in_left;
    assign pack_beat.blen = (left >= LW'(BC)) ? 5'(BC) : left[4:0];
    assign pack_beat.eop  = sub_rsp.last && emit;
    assign pack_beat.data = sub_rsp.data;

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RSP_START;
        end else if (in_fire) begin
            if (sub_rsp.last) begin
                state <= emit ? RSP_START : SUB_START;
            end else begin
                state <= SUB_BODY;
            end
        end
    end

    always_ff @(posedge dma_clk) begin
        if (in_fire) begin
            in_left <= left - LW'(pack_beat.blen);
        end
        if (in_fire && state == RSP_START) begin  // latch on the first beat
            hd_addr <= sub_rsp.head.addr;
            hd_len  <= sub_rsp.head.byte_len;
        end else if (in_fire && state == SUB_START) begin
            hd_len  <= nxt_len;
        end
    end

    // ***********************************************************************
    // merged head store
    // ***********************************************************************
    assign nxt_len   = hd_len + sub_rsp.head.byte_len;
    assign head_push = in_fire && sub_sop && emit;  // first beat of the emitted one

    always_comb begin
        head_in          = '0;
        head_in.addr     = (state == RSP_START) ? sub_rsp.head.addr : hd_addr;
        head_in.byte_len = (state == RSP_START) ? sub_rsp.head.byte_len : nxt_len;
    end

    dma_sync_fifo #(
        .DSIZE (`DMA_HEAD_W),
        .ASIZE (HEAD_DEPTH_LOG)
    ) head_fifo_i (
        .dma_clk (dma_clk),
        .rst_n   (rst_n),
        .wen     (head_push),
        .din     (head_in),
        .ren     (out_fire && out_last),  // pop with the packet's last beat
        .dout    (head_out),
        .full    (head_full),
        .empty   (head_empty)
    );

    rsp_data_fifo data_fifo_i (
        .dma_clk    (dma_clk),
        .rst_n      (rst_n),
        .pack_valid (pack_valid),
        .pack_beat  (pack_beat),
        .pack_ready (pack_ready),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_ready (beat_ready)
    );

    // occupancy in bytes, rounded to whole beats at each eop like the packer
    always_comb begin
        occ_nxt = occ_bytes;
        if (in_fire) begin
            occ_nxt = occ_bytes + LW'(pack_beat.blen);
        end
        if (in_fire && pack_beat.eop) begin
            occ_nxt = {occ_nxt[LW-1:BS] + (LW-BS)'(|occ_nxt[BS-1:0]), {BS{1'b0}}};
        end
    end

    // ***********************************************************************
    // output side
    // ***********************************************************************
    assign out_left   = head_out.byte_len - out_cnt;
    assign out_last   = (out_left <= LW'(BC));
    assign rsp_valid  = beat_valid && !head_empty;  // data and head both present
    assign beat_ready = rsp_ready && !head_empty;
    assign out_fire   = rsp_valid && rsp_ready;

    assign rsp.last = out_last;
    assign rsp.data = beat_data;
    assign rsp.head = head_out;

    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_bytes <= '0;
            out_cnt   <= '0;
            is_avail  <= 1'b0;
        end else begin
            occ_bytes <= occ_nxt - (out_fire ? LW'(BC) : LW'(0));
            is_avail  <= rsp_ready;  // one cycle behind
            if (out_fire) begin
                out_cnt <= out_last ? '0 : out_cnt + LW'(BC);
            end
        end
    end

    // beyond 1024B the credit check against a 64-beat buffer never passes
    a_mrrs_range: assert property (@(posedge dma_clk) disable iff (!rst_n)
        max_rd_req_sz <= FRAG_1024B);

    a_sub_len: assert property (@(posedge dma_clk) disable iff (!rst_n)
        sub_rsp_valid && sub_sop |-> sub_rsp.head.byte_len != '0);

endmodule

/* design/dma_rd_rsp_top.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_rd_rsp_top (
    input  logic                        dma_clk,
    input  logic                        rst_n,
    input  logic                        sub_rsp_valid,  // from PCIe read response
    input  dma_rsp_pkg::sub_rsp_beat_t  sub_rsp,
    output logic                        sub_rsp_ready,
    input  logic                        emit,
    input  dma_pcie_pkg::pcie_frag_sz_e max_rd_req_sz,
    output logic                        rsp_valid,      // towards RDMA engine
    output dma_rsp_pkg::rsp_beat_t      rsp,
    input  logic                        rsp_ready,
    output logic                        is_avail
);

    sub_req_rsp_concat #(
        .HEAD_DEPTH_LOG (`HEAD_DEPTH_LOG)
    ) concat_i (
        .dma_clk       (dma_clk),
        .rst_n         (rst_n),
        .emit          (emit),
        .sub_rsp_valid (sub_rsp_valid),
        .sub_rsp       (sub_rsp),
        .sub_rsp_ready (sub_rsp_ready),
        .max_rd_req_sz (max_rd_req_sz),
        .is_avail      (is_avail),
        .pack_valid    (),  // internal packer taps
        .pack_beat     (),
        .beat_valid    (),
        .beat_data     (),
        .beat_ready    (),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready)
    );

endmodule

/* dv/dma_rd_rsp_tb.sv */
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_rd_rsp_tb;

    import dma_pcie_pkg::*;
    import dma_rsp_pkg::*;

    localparam logic [31:0] SEED = 32'h00b3a50e;
    localparam int BC = `DMA_W_BCNT;
    // bounded by the random test with ten requests near 1 KB at half-rate ready
    localparam int CYCLE_LIMIT = 20000;

    logic          dma_clk;
    logic          rst_n;
    logic          sub_rsp_valid;
    sub_rsp_beat_t sub_rsp;
    logic          sub_rsp_ready;
    logic          emit;
    pcie_frag_sz_e max_rd_req_sz;
    logic          rsp_valid;
    rsp_beat_t     rsp;
    logic          rsp_ready;
    logic          is_avail;

    rsp_beat_t   exp_q[$];                // expected output beats in order
    logic [31:0] data_state = SEED;       // stimulus stream
    logic [31:0] rdy_state  = ~SEED;      // separate stream for rsp_ready
    int          ready_mode = 0;          // 0 low, 1 high, 2 random, 3 toggle
    logic        prev_ready;
    int          cycles     = 0;
    int          err_cnt    = 0;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;

    dma_rd_rsp_top dut_i (
        .dma_clk       (dma_clk),
        .rst_n         (rst_n),
        .sub_rsp_valid (sub_rsp_valid),
        .sub_rsp       (sub_rsp),
        .sub_rsp_ready (sub_rsp_ready),
        .emit          (emit),
        .max_rd_req_sz (max_rd_req_sz),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .is_avail      (is_avail)
    );

    initial begin
        dma_clk = 1'b0;
        forever #4 dma_clk = ~dma_clk;  // 8 ns
    end

    always @(posedge dma_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles, DUT stopped moving", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ***********************************************************************
    // checks
    // ***********************************************************************
    task automatic compare_beat(input string name, input rsp_beat_t exp, input rsp_beat_t act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic end_test(input string name, input int e0);
        if (err_cnt == e0) begin
            pass_cnt++;
            $display("test %s: PASS", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAIL with %0d errors", name, err_cnt - e0);
        end
    endtask

    // output side drives the ready pattern and checks beats and is_avail
    initial begin
        logic exp_avail;
        rsp_ready  = 1'b0;
        prev_ready = 1'b0;
        forever begin
            @(negedge dma_clk);
            exp_avail = prev_ready;  // ready seen at the last rising edge
            case (ready_mode)
                0: rsp_ready = 1'b0;
                1: rsp_ready = 1'b1;
                2: begin
                    rdy_state = xorshift(rdy_state);
                    rsp_ready = rdy_state[0];
                end
                default: rsp_ready = !rsp_ready;
            endcase
            prev_ready = rsp_ready;
            #1;
            if (rst_n) begin
                compare_bit("is_avail", exp_avail, is_avail);
                if (rsp_valid && rsp_ready) begin  // beat moves at next edge
                    if (exp_q.size() == 0) begin
                        note_failure("DUT sent an output beat that no request explains");
                    end else begin
                        compare_beat("rsp", exp_q.pop_front(), rsp);
                    end
                end
            end
        end
    end

    // ***********************************************************************
    // input side
    // ***********************************************************************
    task automatic set_ready_mode(input int m);
        @(posedge dma_clk);  // monitor reads it only on falling edges
        ready_mode = m;
    endtask

    task automatic send_beat(input sub_rsp_beat_t b, input logic em, input int max_wait,
                             output logic taken);
        int waited;
        waited = 0;
        @(negedge dma_clk);
        sub_rsp_valid = 1'b1;
        sub_rsp       = b;
        emit          = em;
        #1;
        while (!sub_rsp_ready && waited < max_wait) begin
            @(negedge dma_clk);
            #1;
            waited++;
        end
        taken = sub_rsp_ready;
        if (taken) begin
            @(posedge dma_clk);
        end
    endtask

    task automatic drop_valid();
        @(negedge dma_clk);
        sub_rsp_valid = 1'b0;
        emit          = 1'b0;
    endtask

    // one request of n_sub sub-responses with its expected beats queued first
    task automatic send_req(input int n_sub, input int lens[4], input logic [63:0] addr,
                            input int first_wait, output logic taken);
        logic [7:0]    req_b[$];
        rsp_beat_t     eb;
        sub_rsp_beat_t b;
        int            total;
        int            nb;
        int            off;
        int            idx;
        int            sub_nb;
        total = 0;
        for (int s = 0; s < n_sub; s++) begin
            for (int i = 0; i < lens[s]; i++) begin
                data_state = xorshift(data_state);
                req_b.push_back(data_state[7:0]);
            end
            total += lens[s];
        end
        nb = (total + BC - 1) / BC;
        for (int k = 0; k < nb; k++) begin  // dense byte stream with a zero tail
            eb = '0;
            for (int j = 0; j < BC; j++) begin
                idx = k * BC + j;
                if (idx < total) begin
                    eb.data[8*j +: 8] = req_b[idx];
                end
            end
            eb.last          = (k == nb - 1);
            eb.head.addr     = addr;
            eb.head.byte_len = `DMA_LEN_WIDTH'(total);
            exp_q.push_back(eb);
        end
        off   = 0;
        taken = 1'b1;
        for (int s = 0; s < n_sub && taken; s++) begin
            b               = '0;
            b.head.addr     = addr + 64'(off);
            b.head.byte_len = `DMA_LEN_WIDTH'(lens[s]);
            sub_nb          = (lens[s] + BC - 1) / BC;
            for (int k = 0; k < sub_nb && taken; k++) begin
                for (int j = 0; j < BC; j++) begin
                    data_state = xorshift(data_state);  // junk above the tail
                    idx = k * BC + j;
                    b.data[8*j +: 8] = (idx < lens[s]) ? req_b[off + idx] : data_state[7:0];
                end
                b.last = (k == sub_nb - 1);
                send_beat(b, s == n_sub - 1, (s == 0 && k == 0) ? first_wait : 4000, taken);
                if (!taken && s == 0 && k == 0) begin
                    for (int p = 0; p < nb; p++) begin  // refused request leaves no output
                        void'(exp_q.pop_back());
                    end
                end else if (!taken) begin
                    note_failure("input stalled in the middle of a request");
                end
            end
            off += lens[s];
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge dma_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%0d expected output beats never came out", exp_q.size()));
        end
    endtask

    // ***********************************************************************
    // tests
    // ***********************************************************************
    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        @(negedge dma_clk);
        #1;
        compare_bit("rsp_valid", 1'b0, rsp_valid);
        compare_bit("is_avail", 1'b0, is_avail);
        compare_bit("sub_rsp_ready", 1'b1, sub_rsp_ready);
        set_ready_mode(3);  // monitor checks the lag
        repeat (12) @(negedge dma_clk);
        set_ready_mode(1);
        end_test("reset state and is_avail", e0);
    endtask

    task automatic run_directed(input string name, input int n_sub, input int lens[4],
                                input logic [63:0] addr);
        logic ok;
        int   e0;
        e0 = err_cnt;
        send_req(n_sub, lens, addr, 100, ok);
        compare_bit("sub_rsp_ready", 1'b1, ok);
        drop_valid();
        wait_drain(1000);
        end_test(name, e0);
    endtask

    task automatic test_random();
        int          lens[4];
        int          n;
        logic [63:0] addr;
        logic        ok;
        int          e0;
        e0 = err_cnt;
        set_ready_mode(2);
        for (int r = 0; r < 10; r++) begin
            data_state = xorshift(data_state);
            n = 1 + int'(data_state % 4);
            for (int s = 0; s < 4; s++) begin
                data_state = xorshift(data_state);
                if (s < n - 1) begin  // held in the buffer until the head is pushed
                    lens[s] = 1 + int'(data_state % 170);
                end else begin
                    lens[s] = 1 + int'(data_state % 512);
                end
            end
            data_state = xorshift(data_state);
            addr[63:32] = data_state;
            data_state = xorshift(data_state);
            addr[31:0] = data_state;
            send_req(n, lens, addr, 4000, ok);
            compare_bit("sub_rsp_ready", 1'b1, ok);
        end
        drop_valid();
        wait_drain(8000);
        set_ready_mode(1);
        end_test("random back-to-back requests", e0);
    endtask

    task automatic test_credit();
        int   lens[4];
        int   occ;    // model data-buffer fill in beats
        int   heads;
        logic fits;
        logic ok;
        int   e0;
        e0    = err_cnt;
        occ   = 0;
        heads = 0;
        ok    = 1'b1;
        set_ready_mode(0);
        @(negedge dma_clk);
        max_rd_req_sz = FRAG_1024B;
        for (int i = 0; i < 6 && ok; i++) begin
            lens = '{40 + 100 * i, 0, 0, 0};
            fits = (occ + (8 << int'(FRAG_1024B)) <= 64) && (heads < 4);
            send_req(1, lens, 64'h0000_0010_0000_0000 + 64'(i * 4096), 20, ok);
            compare_bit("sub_rsp_ready", fits, ok);
            occ += (lens[0] + BC - 1) / BC;
            heads++;
        end
        if (ok) begin
            note_failure("input was never refused while the data buffer held beats");
        end
        drop_valid();
        set_ready_mode(1);
        wait_drain(1000);
        @(negedge dma_clk);
        max_rd_req_sz = FRAG_512B;
        end_test("credit blocking", e0);
    endtask

    initial begin
        int lens[4];
        rst_n         = 1'b0;
        sub_rsp_valid = 1'b0;
        sub_rsp       = '0;
        emit          = 1'b0;
        max_rd_req_sz = FRAG_512B;
        repeat (16) @(posedge dma_clk);
        @(negedge dma_clk);
        rst_n = 1'b1;
        test_reset();
        lens = '{128, 0, 0, 0};
        run_directed("single aligned sub-response", 1, lens, 64'h0000_0004_8000_1000);
        lens = '{37, 250, 91, 0};
        run_directed("three unaligned sub-responses", 3, lens, 64'h0000_0000_0123_4567);
        test_random();
        test_credit();
        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dma_rd_rsp_top.f */
+incdir+design
design/dma_pcie_pkg.sv
design/dma_rsp_pkg.sv
design/dma_sync_fifo.sv
design/rsp_data_fifo.sv
design/sub_req_rsp_concat.sv
design/dma_rd_rsp_top.sv
dv/dma_rd_rsp_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --assert -Wno-fatal -f dma_rd_rsp_top.f \
    --top-module dma_rd_rsp_tb -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -qx "Simulation completed successfully" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL, see sim.log"
    exit 1
fi
